/* Makefile */
# Verilator build and run for the lane joiner testbench
VERILATOR ?= verilator
TOP       ?= tb_lane_join
FILELIST  ?= lane_join.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

PASS_MSG := Simulation completed successfully
SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, so a fatal stop also counts as failure
run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "run passed, see $(LOG)"; \
	else \
	  echo "run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* lane_join.f */
verilog/lane_join_pkg.sv
verilog/lane_fifo.sv
verilog/lane_fence.sv
verilog/beat_slice.sv
verilog/lane_join_top.sv
tb/tb_lane_join.sv

/* tb/tb_lane_join.sv */
/*
  Directed testbench for the lane joiner. Driver tasks play the memory
  banks, a scoreboard joins the lane words seen at the ports and checks
  every wide beat, and a watchdog bounds the run.
*/
`default_nettype none
`timescale 1ns/10ps

module tb_lane_join;

  import lane_join_pkg::*;

  localparam int CLK_HALF     = 4;
  localparam int DRV_DELAY    = 1;
  localparam int RST_CYCLES   = 8;
  localparam int STALL_CYCLES = 30;
  localparam int N_ALIGNED    = 16;
  localparam int N_STAGGER    = 12;
  localparam int N_BP         = 12;
  localparam int N_CLEAR      = 6;
  localparam int N_RAND       = 300;
  localparam int TOTAL_BEATS  = N_ALIGNED + N_STAGGER + N_BP + N_CLEAR + N_RAND;
  // loose upper bound of cycles per beat, gaps and stalls included
  localparam int CYC_PER_BEAT = 16;
  localparam int TIMEOUT_NS   =
    2 * CLK_HALF * (RST_CYCLES + STALL_CYCLES + 100 + TOTAL_BEATS * CYC_PER_BEAT);

  typedef logic [$bits(wide_beat_t)-1:0] value_t;

  logic                       clk_i = 1'b0;
  logic                       rst_ni;
  logic                       clear;
  logic       [NUM_LANES-1:0] lane_valid;
  logic       [NUM_LANES-1:0] lane_ready;
  lane_beat_t [NUM_LANES-1:0] lane_beat;
  logic                       wide_valid;
  logic                       wide_ready;
  wide_beat_t                 wide_beat;

  // lane words accepted but not yet joined, and the joined beats still due
  lane_beat_t lane_q [NUM_LANES][$];
  wide_beat_t exp_q [$];
  int         exp_cyc [$];
  int         cyc = 0;
  int         serial [NUM_LANES];
  int         lanes_done;
  int         errors;
  int         test_id;
  integer     seed = 57826;
  logic       exact_latency;
  logic       stall_prev;
  wide_beat_t stall_beat;

  lane_join_top i_lane_join_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear),
    .lane_valid_i (lane_valid),
    .lane_ready_o (lane_ready),
    .lane_beat_i  (lane_beat),
    .wide_valid_o (wide_valid),
    .wide_ready_i (wide_ready),
    .wide_beat_o  (wide_beat)
  );

  always #(CLK_HALF) clk_i = ~clk_i;

  always @(posedge clk_i)
    cyc <= cyc + 1;

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input value_t expected, input value_t actual);
    if (expected !== actual)
      abort_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual));
  endtask

  // inputs change one small delay after the rising edge
  task automatic wait_cycle();
    @(posedge clk_i);
    #(DRV_DELAY);
  endtask

  // words carry lane, test and a per-lane serial, so stale words stand out
  function automatic lane_beat_t make_word(input int lane, input int num);
    lane_beat_t w;
    w.data = LANE_WIDTH'({lane[7:0], test_id[7:0], num[15:0]});
    w.strb = LANE_STRB'(num[3:0] ^ lane[3:0] ^ 4'h5);
    return w;
  endfunction

  // ready is state only, so its value at the falling edge holds at the next rise
  task automatic drive_lane(input int lane, input lane_beat_t w);
    logic hs;
    lane_valid[lane] = 1'b1;
    lane_beat[lane]  = w;
    hs = 1'b0;
    while (!hs)
    begin
      @(negedge clk_i);
      hs = lane_ready[lane];
      wait_cycle();
    end
    lane_valid[lane] = 1'b0;
  endtask

  task automatic send_words(input int lane, input int n, input int first_gap, input int max_gap);
    int r;
    int gap;
    repeat (first_gap) wait_cycle();
    for (int i = 0; i < n; i++)
    begin
      r = $random(seed);
      gap = (i == 0 || max_gap == 0) ? 0 : (r & 32'h7fff_ffff) % (max_gap + 1);
      repeat (gap) wait_cycle();
      drive_lane(lane, make_word(lane, serial[lane]));
      serial[lane]++;
    end
    lanes_done++;
  endtask

  // lane k starts stagger*k cycles late
  task automatic send_lanes(input int n, input int stagger, input int max_gap);
    lanes_done = 0;
    for (int k = 0; k < NUM_LANES; k++)
    begin
      automatic int lane = k;
      fork
        send_words(lane, n, stagger * lane, max_gap);
      join_none
    end
    wait (lanes_done == NUM_LANES);
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0)
      wait_cycle();
    repeat (2) wait_cycle();
  endtask

  // beat k is the k-th word of every lane, lane 0 in the low slot
  task automatic join_lanes();
    wide_beat_t b;
    lane_beat_t w;
    logic       complete;
    complete = 1'b1;
    for (int k = 0; k < NUM_LANES; k++)
      if (lane_q[k].size() == 0)
        complete = 1'b0;
    while (complete)
    begin
      for (int k = 0; k < NUM_LANES; k++)
      begin
        w = lane_q[k].pop_front();
        b.data[k] = w.data;
        b.strb[k] = w.strb;
        if (lane_q[k].size() == 0)
          complete = 1'b0;
      end
      exp_q.push_back(b);
      exp_cyc.push_back(cyc);
    end
  endtask

  task automatic check_output();
    wide_beat_t expected;
    int         latency;
    if (exp_q.size() == 0)
      abort_run("a wide beat came out with no complete set of lane words behind it");
    else
    begin
      expected = exp_q.pop_front();
      latency  = cyc - exp_cyc.pop_front();
      check_value("wide_beat_o", value_t'(expected), value_t'(wide_beat));
      if (exact_latency)
        check_value("wide latency", value_t'(2), value_t'(latency));
      else if (latency < 2)
        abort_run("a wide beat came out before all of its lane words were accepted");
    end
  endtask

  // sampled at the falling edge, i.e. what the next rising edge will take
  always @(negedge clk_i)
  begin
    if (rst_ni && clear)
    begin
      // clear drops every buffered word, so the model forgets them as well
      for (int k = 0; k < NUM_LANES; k++)
        lane_q[k].delete();
      exp_q.delete();
      exp_cyc.delete();
      stall_prev = 1'b0;
    end
    else if (rst_ni)
    begin
      // a stalled beat has to stay put until it is taken
      if (stall_prev)
      begin
        check_value("wide_valid_o", value_t'(1), value_t'(wide_valid));
        check_value("wide_beat_o", value_t'(stall_beat), value_t'(wide_beat));
      end
      if (wide_valid && wide_ready)
        check_output();
      stall_prev = wide_valid & ~wide_ready;
      stall_beat = wide_beat;
      for (int k = 0; k < NUM_LANES; k++)
        if (lane_valid[k] && lane_ready[k])
          lane_q[k].push_back(lane_beat[k]);
      join_lanes();
    end
  end

  task automatic test_aligned();
    test_id = 1;
    exact_latency = 1'b1;
    wide_ready = 1'b1;
    send_lanes(N_ALIGNED, 0, 0);
    wait_idle();
    exact_latency = 1'b0;
  endtask

  task automatic test_staggered();
    test_id = 2;
    // lane 0 leads, later lanes start 3, 6 and 9 cycles behind
    send_lanes(N_STAGGER, 3, 3);
    wait_idle();
  endtask

  task automatic test_backpressure();
    test_id = 3;
    wide_ready = 1'b0;
    fork
      send_lanes(N_BP, 0, 0);
      begin
        repeat (STALL_CYCLES) wait_cycle();
        // slice, fence and every FIFO are full by now
        check_value("lane_ready_o", value_t'(0), value_t'(lane_ready));
        check_value("wide_valid_o", value_t'(1), value_t'(wide_valid));
        wide_ready = 1'b1;
      end
    join
    wait_idle();
  endtask

  task automatic test_clear();
    test_id = 4;
    wide_ready = 1'b0;
    // one beat parks in the slice, then lanes 0 and 1 leave a partial fence
    // and lane 0 goes on until its FIFO is full
    send_lanes(1, 0, 0);
    fork
      send_words(0, 6, 0, 0);
      send_words(1, 2, 0, 0);
    join
    repeat (3) wait_cycle();
    check_value("lane_ready_o[0]", value_t'(0), value_t'(lane_ready[0]));
    clear = 1'b1;
    wait_cycle();
    clear = 1'b0;
    check_value("wide_valid_o", value_t'(0), value_t'(wide_valid));
    check_value("lane_ready_o", value_t'({NUM_LANES{1'b1}}), value_t'(lane_ready));
    test_id = 5;
    wide_ready = 1'b1;
    send_lanes(N_CLEAR, 0, 1);
    wait_idle();
  endtask

  task automatic test_random();
    int   r;
    logic drivers_done;
    test_id = 6;
    drivers_done = 1'b0;
    fork
      begin
        send_lanes(N_RAND, 0, 3);
        drivers_done = 1'b1;
      end
      while (!drivers_done)
      begin
        // downstream takes a beat in about three cycles out of four
        r = $random(seed);
        wide_ready = r[0] | r[1];
        wait_cycle();
      end
    join
    wide_ready = 1'b1;
    wait_idle();
    // once drained, no beat and no buffered word is left inside
    check_value("wide_valid_o", value_t'(0), value_t'(wide_valid));
    check_value("lane_ready_o", value_t'({NUM_LANES{1'b1}}), value_t'(lane_ready));
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    abort_run("watchdog expired before the tests finished");
  end

  initial
  begin
    clear = 1'b0;
    lane_valid = '0;
    lane_beat = '0;
    wide_ready = 1'b0;
    exact_latency = 1'b0;
    stall_prev = 1'b0;
    errors = 0;
    test_id = 0;
    lanes_done = 0;
    for (int k = 0; k < NUM_LANES; k++)
      serial[k] = 0;
    rst_ni = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #(DRV_DELAY);
    rst_ni = 1'b1;
    check_value("wide_valid_o", value_t'(0), value_t'(wide_valid));
    check_value("lane_ready_o", value_t'({NUM_LANES{1'b1}}), value_t'(lane_ready));
    test_aligned();
    test_staggered();
    test_backpressure();
    test_clear();
    test_random();
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/beat_slice.sv */
/*
  Full-throughput register slice for a valid/ready stream.
  Both the forward path and the input ready come from flops; a skid
  entry absorbs the one beat that slips in after the output stalls.
*/
`default_nettype none
`timescale 1ns/10ps

module beat_slice #(
  parameter type beat_t = lane_join_pkg::wide_beat_t
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  beat_t in_beat_i,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output beat_t out_beat_o
);

  logic  main_valid_q;
  logic  skid_valid_q;
  beat_t main_beat_q;
  beat_t skid_beat_q;
  logic  in_fire;
  logic  main_free;

  // skid full means the upstream must wait, and this is a flop output
  assign in_ready_o = ~skid_valid_q;
  assign in_fire    = in_valid_i & in_ready_o;
  // main can take a beat when empty or being drained this cycle
  assign main_free  = ~main_valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end
    else if (clear_i)
    begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end
    else if (main_free)
    begin
      // the skid entry is older, so it goes first
      main_valid_q <= skid_valid_q | in_fire;
      skid_valid_q <= 1'b0;
    end
    else if (in_fire)
      skid_valid_q <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (main_free)
      main_beat_q <= skid_valid_q ? skid_beat_q : in_beat_i;
    else if (in_fire)
      skid_beat_q <= in_beat_i;
  end

  assign out_valid_o = main_valid_q;
  assign out_beat_o  = main_beat_q;

endmodule

`default_nettype wire

/* verilog/lane_fence.sv */
/*
  Synchronizes NUM_LANES valid/ready streams into one joint handshake.
  A lane that shows up before the others is captured and held, and all
  lanes are released together once each is live or held.
*/
`default_nettype none
`timescale 1ns/10ps

module lane_fence #(
  parameter type beat_t = lane_join_pkg::lane_beat_t
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  logic [lane_join_pkg::NUM_LANES-1:0]   in_valid_i,
  output logic [lane_join_pkg::NUM_LANES-1:0]   in_ready_o,
  input  beat_t [lane_join_pkg::NUM_LANES-1:0]  in_beat_i,
  output logic                                  out_valid_o,
  input  logic [lane_join_pkg::NUM_LANES-1:0]   out_ready_i,
  output beat_t [lane_join_pkg::NUM_LANES-1:0]  out_beat_o
);

  import lane_join_pkg::*;

  logic  [NUM_LANES-1:0] hold_q;
  logic  [NUM_LANES-1:0] hold_d;
  logic  [NUM_LANES-1:0] capture;
  beat_t [NUM_LANES-1:0] hold_beat_q;
  logic                  all_present;

  // every lane either has a live word or already parked one
  assign all_present = &(in_valid_i | hold_q);
  assign out_valid_o = all_present;

  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      // a held lane takes nothing more until the joint transfer
      in_ready_o[k] = out_ready_i[k] & ~hold_q[k];

      // an early lane is parked only when its FIFO really hands the word
      // over, otherwise the same word would be taken twice
      capture[k] = ~all_present & in_valid_i[k] & in_ready_o[k];

      if (all_present)
        hold_d[k] = hold_q[k] & ~out_ready_i[k];
      else
        hold_d[k] = hold_q[k] | capture[k];

      out_beat_o[k] = hold_q[k] ? hold_beat_q[k] : in_beat_i[k];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      hold_q <= '0;
    else if (clear_i)
      hold_q <= '0;
    else
      hold_q <= hold_d;
  end

  // parked words, valid only under their hold flag
  always_ff @(posedge clk_i)
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      if (capture[k])
        hold_beat_q[k] <= in_beat_i[k];
    end
  end

endmodule

`default_nettype wire

/* verilog/lane_fifo.sv */
/*
  Per-lane buffer between a bank port and the fence.
  A circular buffer feeds a registered output stage, so a word written
  in one cycle shows at the output in the next one. clear_i empties it.
*/
`default_nettype none
`timescale 1ns/10ps

module lane_fifo #(
  parameter type beat_t = lane_join_pkg::lane_beat_t
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  beat_t in_beat_i,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output beat_t out_beat_o
);

  import lane_join_pkg::*;

  typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] cnt_t;

  beat_t mem_q [FIFO_DEPTH];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  cnt_q;
  logic  out_valid_q;
  beat_t out_beat_q;

  logic push;
  logic pop;
  logic load_out;
  logic mem_to_out;
  logic push_to_out;
  logic push_to_mem;

  // ready depends on stored state only, so a full buffer refuses a write
  // even when the output is read in the same cycle
  assign in_ready_o = (cnt_q != cnt_t'(FIFO_DEPTH));
  assign push       = in_valid_i & in_ready_o;
  assign pop        = out_valid_q & out_ready_i;

  // the output stage takes a new word when it is empty or being read
  assign load_out    = ~out_valid_q | pop;
  assign mem_to_out  = load_out & (cnt_q != '0);
  // with an empty buffer the incoming word skips straight to the output
  assign push_to_out = load_out & (cnt_q == '0) & push;
  assign push_to_mem = push & ~push_to_out;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
    end
    else if (clear_i)
    begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      if (push_to_mem)
        wr_ptr_q <= (wr_ptr_q == ptr_t'(FIFO_DEPTH-1)) ? '0 : wr_ptr_q + ptr_t'(1);
      if (mem_to_out)
        rd_ptr_q <= (rd_ptr_q == ptr_t'(FIFO_DEPTH-1)) ? '0 : rd_ptr_q + ptr_t'(1);
      cnt_q <= cnt_q + cnt_t'(push_to_mem) - cnt_t'(mem_to_out);
      if (load_out)
        out_valid_q <= mem_to_out | push_to_out;
    end
  end

  // storage and output word carry payload only
  always_ff @(posedge clk_i)
  begin
    if (push_to_mem)
      mem_q[wr_ptr_q] <= in_beat_i;
    if (mem_to_out)
      out_beat_q <= mem_q[rd_ptr_q];
    else if (push_to_out)
      out_beat_q <= in_beat_i;
  end

  assign out_valid_o = out_valid_q;
  assign out_beat_o  = out_beat_q;

endmodule

`default_nettype wire

/* verilog/lane_join_pkg.sv */
/*
  Shared widths, depths and beat types of the lane joiner.
  Lane streams carry lane_beat_t, the joined output carries wide_beat_t.
  Modules pull these in by a wildcard import in their body.
*/
`default_nettype none

package lane_join_pkg;

  // number of memory bank lanes that make up one wide operand
  localparam int unsigned NUM_LANES = 4;

  // data bits carried by one lane word
  localparam int unsigned LANE_WIDTH = 32;

  // one strobe bit per byte of a lane word
  localparam int unsigned LANE_STRB = LANE_WIDTH / 8;

  // words buffered per lane before its ready drops
  localparam int unsigned FIFO_DEPTH = 4;

  // one word as returned by a single bank port
  typedef struct packed {
    logic [LANE_WIDTH-1:0] data;
    logic [LANE_STRB-1:0]  strb;
  } lane_beat_t;

  // the joined beat, lane 0 sits in the least significant slot of both fields
  typedef struct packed {
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] data;
    logic [NUM_LANES-1:0][LANE_STRB-1:0]  strb;
  } wide_beat_t;

endpackage

`default_nettype wire

/* verilog/lane_join_top.sv */
/*
  Joins NUM_LANES bank word streams into one wide beat.
  Each lane is buffered, the fence lines the lanes up, and the joined
  beat leaves through a register slice. clear_i flushes every stage.
*/
`default_nettype none
`timescale 1ns/10ps

module lane_join_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              clear_i,
  input  logic [lane_join_pkg::NUM_LANES-1:0]               lane_valid_i,
  output logic [lane_join_pkg::NUM_LANES-1:0]               lane_ready_o,
  input  lane_join_pkg::lane_beat_t [lane_join_pkg::NUM_LANES-1:0] lane_beat_i,
  output logic                                              wide_valid_o,
  input  logic                                              wide_ready_i,
  output lane_join_pkg::wide_beat_t                         wide_beat_o
);

  import lane_join_pkg::*;

  logic       [NUM_LANES-1:0] fifo_valid;
  logic       [NUM_LANES-1:0] fifo_ready;
  lane_beat_t [NUM_LANES-1:0] fifo_beat;
  logic                       fence_valid;
  logic       [NUM_LANES-1:0] fence_ready;
  lane_beat_t [NUM_LANES-1:0] fence_beat;
  wide_beat_t                 joined_beat;
  logic                       slice_ready;

  // one buffer per bank port, so a slow bank does not stall the others
  for (genvar k = 0; k < NUM_LANES; k++)
  begin : g_lane
    lane_fifo #(
      .beat_t (lane_beat_t)
    ) i_lane_fifo (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .clear_i     (clear_i),
      .in_valid_i  (lane_valid_i[k]),
      .in_ready_o  (lane_ready_o[k]),
      .in_beat_i   (lane_beat_i[k]),
      .out_valid_o (fifo_valid[k]),
      .out_ready_i (fifo_ready[k]),
      .out_beat_o  (fifo_beat[k])
    );
  end

  lane_fence #(
    .beat_t (lane_beat_t)
  ) i_lane_fence (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_valid_i  (fifo_valid),
    .in_ready_o  (fifo_ready),
    .in_beat_i   (fifo_beat),
    .out_valid_o (fence_valid),
    .out_ready_i (fence_ready),
    .out_beat_o  (fence_beat)
  );

  // all fenced lanes move as one beat, so they share the slice ready
  assign fence_ready = {NUM_LANES{slice_ready}};

  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      joined_beat.data[k] = fence_beat[k].data;
      joined_beat.strb[k] = fence_beat[k].strb;
    end
  end

  beat_slice #(
    .beat_t (wide_beat_t)
  ) i_beat_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_valid_i  (fence_valid),
    .in_ready_o  (slice_ready),
    .in_beat_i   (joined_beat),
    .out_valid_o (wide_valid_o),
    .out_ready_i (wide_ready_i),
    .out_beat_o  (wide_beat_o)
  );

endmodule

`default_nettype wire
